// File: files.f
design/l1_wb_pkg.sv
design/sync_fifo.sv
design/l1_to_wishbone.sv
design/wb_memory.sv
design/l1_wb_subsystem.sv
verif/l1_wb_properties.sv
verif/l1_wb_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the cache-to-wishbone testbench with Verilator, runs it,
# and decides pass or fail from the simulation output.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module l1_wb_tb -f files.f -o l1_wb_sim; then
    echo "verilator build failed"
    exit 1
fi

# keep going past the first assertion so the testbench can count them
output=$(./obj_dir/l1_wb_sim +verilator+error+limit+1000 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF 'All tests passed!' <<< "$output"; then
    exit 0
fi

echo "simulation did not report success"
exit 1

// File: verif/l1_wb_tb.sv
// ------------------------------------------------
// testbench for the l1-to-wishbone subsystem. runs
// an operation table against a shadow memory and
// checks every read return in order.
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module l1_wb_tb
    import l1_wb_pkg::*;
();

    localparam int CLK_PERIOD = 40;                      // ns.
    localparam int LANE_WIDTH = DATA_WIDTH / BE_WIDTH;   // bits per byte lane.

    typedef struct packed {
        logic        rnw;
        addr_t       addr;
        burst_mask_t mask;
        sub_id_t     sub_id;
        be_t         be;      // used by writes only.
    } op_t;

    logic          clk;
    logic          rst_n;
    l1_request_t   req;
    logic          req_valid;
    logic          req_ready;
    l1_wr_data_t   wr;
    logic          wr_valid;
    logic          wr_ready;
    l1_rd_return_t rd;
    logic          rd_valid;

    op_t           op_table [$];        // rows applied in order.
    l1_rd_return_t expected_q [$];      // read words still to come back.
    data_t         shadow [MEM_WORDS];  // model of the memory contents.
    logic [31:0]   lfsr_state = 32'h821;
    logic          saw_backpressure = 1'b0;
    int            checks = 0;
    int            errors = 0;

    l1_wb_subsystem dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .wr        (wr),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .rd        (rd),
        .rd_valid  (rd_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input data_t actual, input data_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL t=%0t %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // fibonacci lfsr on x^32 + x^22 + x^2 + x + 1 stepped once per bit.
    function automatic data_t next_random_word();
        data_t word;
        logic  feedback;
        word = '0;
        for (int bit_i = 0; bit_i < DATA_WIDTH; bit_i++) begin
            word = {word[DATA_WIDTH-2:0], lfsr_state[31]};
            feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
        end
        return word;
    endfunction

    // word k of the aligned block around addr.
    function automatic addr_t block_word(input addr_t addr, input burst_mask_t mask, input int k);
        return (addr & ~addr_t'(mask)) | addr_t'(k);
    endfunction

    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input be_t be);
        data_t merged;
        merged = old_word;
        for (int lane = 0; lane < BE_WIDTH; lane++) begin
            if (be[lane]) begin
                merged[lane*LANE_WIDTH +: LANE_WIDTH] = new_word[lane*LANE_WIDTH +: LANE_WIDTH];
            end
        end
        return merged;
    endfunction

    function automatic void add_op(input logic rnw, input addr_t addr, input burst_mask_t mask,
                                   input sub_id_t sub_id, input be_t be);
        op_t row;
        row.rnw    = rnw;
        row.addr   = addr;
        row.mask   = mask;
        row.sub_id = sub_id;
        row.be     = be;
        op_table.push_back(row);
    endfunction

    task automatic load_table();
        add_op(1'b0, 30'h010, 5'd0, 2'd0, 4'hF);  // single word.
        add_op(1'b1, 30'h010, 5'd0, 2'd1, 4'hF);
        add_op(1'b0, 30'h010, 5'd0, 2'd0, 4'b0101);  // byte lanes.
        add_op(1'b0, 30'h010, 5'd0, 2'd0, 4'b1000);
        add_op(1'b1, 30'h010, 5'd0, 2'd2, 4'hF);
        add_op(1'b0, 30'h011, 5'd0, 2'd0, 4'hF);
        add_op(1'b0, 30'h011, 5'd0, 2'd0, 4'b0010);
        add_op(1'b1, 30'h011, 5'd0, 2'd3, 4'hF);
        add_op(1'b0, 30'h021, 5'd1, 2'd0, 4'hF);  // bursts, some unaligned.
        add_op(1'b1, 30'h020, 5'd1, 2'd0, 4'hF);
        add_op(1'b0, 30'h046, 5'd3, 2'd0, 4'hF);
        add_op(1'b1, 30'h045, 5'd3, 2'd1, 4'hF);
        add_op(1'b0, 30'h08B, 5'd7, 2'd0, 4'hF);
        add_op(1'b1, 30'h08D, 5'd7, 2'd2, 4'hF);
        add_op(1'b0, 30'h089, 5'd3, 2'd0, 4'b0110);  // partial lanes over a burst.
        add_op(1'b1, 30'h08A, 5'd7, 2'd3, 4'hF);
        add_op(1'b0, 30'h0C4, 5'd7, 2'd0, 4'hF);
        add_op(1'b1, 30'h0C0, 5'd7, 2'd0, 4'hF);
        add_op(1'b1, 30'h010, 5'd0, 2'd3, 4'hF);  // interleaved tags.
        add_op(1'b1, 30'h046, 5'd0, 2'd0, 4'hF);
        add_op(1'b1, 30'h021, 5'd0, 2'd2, 4'hF);
        add_op(1'b1, 30'h08F, 5'd1, 2'd1, 4'hF);
        add_op(1'b1, 30'h011, 5'd0, 2'd0, 4'hF);
        add_op(1'b1, 30'h088, 5'd7, 2'd0, 4'hF);  // back to back, fills the queue.
        add_op(1'b1, 30'h0C0, 5'd7, 2'd1, 4'hF);
        add_op(1'b1, 30'h044, 5'd3, 2'd2, 4'hF);
        add_op(1'b1, 30'h08C, 5'd7, 2'd3, 4'hF);
        add_op(1'b1, 30'h0C7, 5'd7, 2'd0, 4'hF);
        add_op(1'b1, 30'h020, 5'd1, 2'd1, 4'hF);
        add_op(1'b1, 30'h010, 5'd0, 2'd2, 4'hF);
        add_op(1'b1, 30'h08B, 5'd7, 2'd3, 4'hF);
        add_op(1'b1, 30'h0C2, 5'd7, 2'd0, 4'hF);
        add_op(1'b1, 30'h045, 5'd3, 2'd1, 4'hF);
        add_op(1'b1, 30'h011, 5'd0, 2'd2, 4'hF);
        add_op(1'b1, 30'h0C3, 5'd7, 2'd3, 4'hF);
    endtask

    // called 2 ns after an edge; ready is stable until the next edge.
    task automatic send_request(input l1_request_t r);
        req       = r;
        req_valid = 1'b1;
        while (!req_ready) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);  // taken on this edge.
        #2;
        req_valid = 1'b0;
    endtask

    task automatic send_word(input l1_wr_data_t w);
        wr       = w;
        wr_valid = 1'b1;
        while (!wr_ready) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #2;
        wr_valid = 1'b0;
    endtask

    task automatic apply_op(input op_t op);
        l1_request_t   r;
        l1_wr_data_t   w;
        l1_rd_return_t exp;
        data_t         word;
        addr_t         a;
        r.addr       = op.addr;
        r.rnw        = op.rnw;
        r.burst_mask = op.mask;
        r.sub_id     = op.sub_id;
        if (op.rnw) begin
            for (int k = 0; k <= int'(op.mask); k++) begin
                a          = block_word(op.addr, op.mask, k);  // ascending from the base.
                exp.data   = shadow[int'(a[MEM_INDEX_WIDTH-1:0])];
                exp.sub_id = op.sub_id;
                expected_q.push_back(exp);
            end
            send_request(r);
        end else begin
            send_request(r);
            for (int k = 0; k <= int'(op.mask); k++) begin
                word = next_random_word();
                a = block_word(op.addr, op.mask, k);
                shadow[int'(a[MEM_INDEX_WIDTH-1:0])] =
                    merge_bytes(shadow[int'(a[MEM_INDEX_WIDTH-1:0])], word, op.be);
                w.data = word;
                w.be   = op.be;
                send_word(w);
            end
        end
    endtask

    task automatic finish_run();
        if (dut_i.bridge_i.props_i.failures != 0) begin
            errors += dut_i.bridge_i.props_i.failures;
            $display("bound assertions failed %0d times", dut_i.bridge_i.props_i.failures);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // outputs are settled at the falling edge.
    always @(negedge clk) begin
        if (rst_n && req_valid && !req_ready) begin
            saw_backpressure <= 1'b1;
        end
        if (rst_n && rd_valid) begin
            if (expected_q.size() == 0) begin
                errors++;
                $display("rd_valid at %0t with no read word outstanding", $time);
            end else begin
                check_value("rd.data", rd.data, expected_q[0].data);
                check_value("rd.sub_id", data_t'(rd.sub_id), data_t'(expected_q[0].sub_id));
                void'(expected_q.pop_front());
            end
        end
    end

    initial begin
        rst_n     = 1'b0;
        req       = '0;
        req_valid = 1'b0;
        wr        = '0;
        wr_valid  = 1'b0;
        load_table();
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_value("rd_valid", data_t'(rd_valid), '0);  // idle after reset.
        check_value("req_ready", data_t'(req_ready), 32'd1);
        check_value("wr_ready", data_t'(wr_ready), 32'd1);
        foreach (op_table[i]) begin
            apply_op(op_table[i]);
        end
        while (expected_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);  // catch any late extra return.
        if (!saw_backpressure) begin
            errors++;
            $display("req_ready never went low during the back-to-back reads");
        end
        finish_run();
    end

    // bounded by the table length.
    initial begin
        #1;
        repeat (op_table.size() * 80) @(posedge clk);
        errors++;
        $display("timeout: run did not finish, %0d read words still expected",
                 expected_q.size());
        finish_run();
    end

endmodule

`default_nettype wire

// File: verif/l1_wb_properties.sv
// ------------------------------------------------
// wishbone handshake and read-return assertions,
// bound into every l1_to_wishbone instance.
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module l1_wb_properties
    import l1_wb_pkg::*;
(
    input wire logic    clk,
    input wire logic    rst_n,
    input wire wb_m2s_t wb_out,
    input wire wb_s2m_t wb_in,
    input wire logic    rd_valid
);

    int   failures = 0;  // assertion failures so far.
    logic read_ack;      // a read beat completing this cycle.

    assign read_ack = wb_out.stb & wb_in.ack & ~wb_out.we;

    // a waiting beat keeps stb, cyc, address and direction until its ack.
    stb_held_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_out.stb && !wb_in.ack) |=>
            (wb_out.stb && wb_out.cyc && $stable(wb_out.adr) && $stable(wb_out.we)))
        else begin
            failures++;
            $error("stb dropped or changed before its ack");
        end

    ack_under_stb: assert property (@(posedge clk) disable iff (!rst_n)
        wb_in.ack |-> wb_out.stb)
        else begin
            failures++;
            $error("ack seen without stb");
        end

    // reads always take the whole word.
    sel_full_on_read: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_out.stb && !wb_out.we) |-> (wb_out.sel == '1))
        else begin
            failures++;
            $error("partial sel on a read beat");
        end

    rd_valid_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid |-> $past(read_ack))
        else begin
            failures++;
            $error("rd_valid without a read ack");
        end

endmodule

bind l1_to_wishbone l1_wb_properties props_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_out   (wb_out),
    .wb_in    (wb_in),
    .rd_valid (rd_valid)
);

`default_nettype wire

// File: design/l1_wb_subsystem.sv
// ------------------------------------------------
// top level joining the cache-side bridge to its
// wishbone memory for end-to-end checking.
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module l1_wb_subsystem
    import l1_wb_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire l1_request_t req,
    input  wire logic        req_valid,
    output logic             req_ready,
    input  wire l1_wr_data_t wr,
    input  wire logic        wr_valid,
    output logic             wr_ready,
    output l1_rd_return_t    rd,
    output logic             rd_valid
);

    wb_m2s_t wb_m2s;  // bridge to memory.
    wb_s2m_t wb_s2m;  // memory to bridge.

    l1_to_wishbone bridge_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .wr        (wr),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .rd        (rd),
        .rd_valid  (rd_valid),
        .wb_out    (wb_m2s),
        .wb_in     (wb_s2m)
    );

    wb_memory memory_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_in  (wb_m2s),
        .wb_out (wb_s2m)
    );

endmodule

`default_nettype wire

// File: design/wb_memory.sv
// ------------------------------------------------
// wishbone slave word memory with byte-lane writes.
// every beat is acked one cycle after stb, so each
// beat takes two cycles and dat_r is valid with ack.
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module wb_memory
    import l1_wb_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire wb_m2s_t wb_in,
    output wb_s2m_t      wb_out
);

    localparam int LANE_WIDTH = DATA_WIDTH / BE_WIDTH;  // bits per byte lane.

    data_t                      mem [MEM_WORDS]; // contents, not reset.
    logic [MEM_INDEX_WIDTH-1:0] index;           // low word-address bits.
    logic                       access;          // new beat seen this cycle.
    logic                       ack_q;
    data_t                      dat_r_q;

    assign index  = wb_in.adr[MEM_INDEX_WIDTH-1:0];
    // ack low means the current stb has not been served yet.
    assign access = wb_in.cyc & wb_in.stb & ~ack_q;

    // ack pulses for one cycle per beat.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access && wb_in.we) begin
            for (int lane = 0; lane < BE_WIDTH; lane++) begin
                if (wb_in.sel[lane]) begin
                    mem[index][lane*LANE_WIDTH +: LANE_WIDTH] <=
                        wb_in.dat_w[lane*LANE_WIDTH +: LANE_WIDTH];  // enabled lanes only.
                end
            end
        end
    end

    // read word is captured with the beat, so it lines up with ack.
    always_ff @(posedge clk) begin
        if (access) begin
            dat_r_q <= mem[index];
        end
    end

    assign wb_out.dat_r = dat_r_q;
    assign wb_out.ack   = ack_q;

endmodule

`default_nettype wire

// File: design/l1_to_wishbone.sv
// ------------------------------------------------
// bridge from the l1 refill/write-back port to a
// classic wishbone master. requests and write data
// are queued, bursts are split into single beats.
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module l1_to_wishbone
    import l1_wb_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    // cache side.
    input  wire l1_request_t req,
    input  wire logic        req_valid,
    output logic             req_ready,
    input  wire l1_wr_data_t wr,
    input  wire logic        wr_valid,
    output logic             wr_ready,
    output l1_rd_return_t    rd,
    output logic             rd_valid,
    // wishbone side.
    output wb_m2s_t          wb_out,
    input  wire wb_s2m_t     wb_in
);

    l1_request_t request_head;   // request being walked.
    logic        request_valid;
    logic        request_full;
    logic        request_pop;

    l1_wr_data_t data_head;      // next write word.
    logic        data_valid;
    logic        data_full;
    logic        data_pop;

    burst_mask_t beat_count;     // beats finished for the head request.
    logic        beat_active;    // stb for the current beat.
    logic        beat_done;      // stb and ack together.
    logic        last_beat;

    assign req_ready = ~request_full;   // ready is simply not full.
    assign wr_ready  = ~data_full;

    sync_fifo #(
        .WIDTH ($bits(l1_request_t)),
        .DEPTH (MAX_REQUESTS)
    ) request_fifo_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (req_valid & req_ready),
        .pop      (request_pop),
        .data_in  (req),
        .data_out (request_head),
        .valid    (request_valid),
        .full     (request_full)
    );

    sync_fifo #(
        .WIDTH ($bits(l1_wr_data_t)),
        .DEPTH (MAX_REQUESTS)
    ) data_fifo_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (wr_valid & wr_ready),
        .pop      (data_pop),
        .data_in  (wr),
        .data_out (data_head),
        .valid    (data_valid),
        .full     (data_full)
    );

    // a write beat waits until its data word is at the queue head.
    assign beat_active = request_valid & (request_head.rnw | data_valid);
    assign beat_done   = beat_active & wb_in.ack;
    assign last_beat   = (beat_count == request_head.burst_mask);

    assign request_pop = beat_done & last_beat;          // retire after final beat.
    assign data_pop    = beat_done & ~request_head.rnw;  // one word per write ack.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_count <= '0;
        end else if (request_pop) begin
            beat_count <= '0;                 // next request starts at its block base.
        end else if (beat_done) begin
            beat_count <= beat_count + 1'b1;
        end
    end

    // upper bits pass through, masked low bits come from the beat count.
    assign wb_out.adr = {request_head.addr[ADDR_WIDTH-1:BURST_WIDTH],
                         (request_head.addr[BURST_WIDTH-1:0] & ~request_head.burst_mask) |
                         (beat_count & request_head.burst_mask)};
    assign wb_out.dat_w = data_head.data;
    assign wb_out.sel   = request_head.rnw ? '1 : data_head.be;  // reads take the full word.
    assign wb_out.we    = ~request_head.rnw;
    assign wb_out.stb   = beat_active;
    assign wb_out.cyc   = beat_active;  // one cycle per beat, no held bus.

    // read return, one cycle behind the ack.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= beat_done & request_head.rnw;
        end
    end

    always_ff @(posedge clk) begin
        rd.data   <= wb_in.dat_r;           // payload, no reset.
        rd.sub_id <= request_head.sub_id;
    end

endmodule

`default_nettype wire

// File: design/sync_fifo.sv
// ------------------------------------------------
// single-clock queue of WIDTH-bit entries.
// head is visible on data_out while valid is high.
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 8
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             push,
    input  wire logic             pop,
    input  wire logic [WIDTH-1:0] data_in,
    output logic      [WIDTH-1:0] data_out,
    output logic                  valid,
    output logic                  full
);

    localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]       storage [DEPTH]; // entries, no reset.
    logic [PTR_WIDTH-1:0]   wr_ptr;          // next slot to fill.
    logic [PTR_WIDTH-1:0]   rd_ptr;          // current head.
    logic [COUNT_WIDTH-1:0] count;           // occupancy.
    logic                   do_push;
    logic                   do_pop;

    assign do_push = push & ~full;   // drop pushes into a full queue.
    assign do_pop  = pop & valid;    // drop pops from an empty queue.

    assign valid    = (count != '0);
    assign full     = (count == COUNT_WIDTH'(DEPTH));
    assign data_out = storage[rd_ptr]; // head without a pop.

    always_ff @(posedge clk) begin
        if (do_push) begin
            storage[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                // wrap explicitly so odd depths work too.
                wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end  // both at once leaves count alone.
        end
    end

endmodule

`default_nettype wire

// File: design/l1_wb_pkg.sv
// ------------------------------------------------
// shared sizes, vector types and bundles for the
// cache-to-wishbone bridge, its memory and bench.
// import with a wildcard in each module header.
// ------------------------------------------------
`default_nettype none

package l1_wb_pkg;

    localparam int ADDR_WIDTH   = 30;  // word address.
    localparam int DATA_WIDTH   = 32;  // one data word.
    localparam int BE_WIDTH     = 4;   // one enable per byte lane.
    localparam int SUB_ID_WIDTH = 2;   // request tag.
    localparam int BURST_WIDTH  = 5;   // up to 32 beats.
    localparam int MAX_REQUESTS = 8;   // depth of both bridge queues.
    localparam int MEM_WORDS    = 256; // backing memory size.
    localparam int MEM_INDEX_WIDTH = $clog2(MEM_WORDS); // word index into the memory.

    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [BE_WIDTH-1:0]     be_t;
    typedef logic [SUB_ID_WIDTH-1:0] sub_id_t;
    // low address bits that step inside a burst, contiguous from bit 0.
    typedef logic [BURST_WIDTH-1:0]  burst_mask_t;

    typedef struct packed {
        addr_t       addr;       // any word inside the target block.
        logic        rnw;        // 1 for refill, 0 for write-back.
        burst_mask_t burst_mask; // beats minus one.
        sub_id_t     sub_id;     // echoed on the read return.
    } l1_request_t;

    typedef struct packed {
        data_t data;
        be_t   be;
    } l1_wr_data_t;

    typedef struct packed {
        data_t   data;
        sub_id_t sub_id;
    } l1_rd_return_t;

    typedef struct packed {
        addr_t adr;
        data_t dat_w;
        be_t   sel;
        logic  we;
        logic  stb;
        logic  cyc;
    } wb_m2s_t;

    typedef struct packed {
        data_t dat_r;
        logic  ack;
    } wb_s2m_t;

endpackage

`default_nettype wire
